//--- pool_layer.f
+incdir+include
design/pool_pkg.sv
design/delay_line.sv
design/ifm_buffer.sv
design/line_fifo.sv
design/max_pool_unit.sv
design/ofm_buffer.sv
design/pool_ctrl.sv
design/pool_layer_top.sv
sim/pool_layer_sva.sv
sim/pool_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the pool layer testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
    --top-module pool_layer_tb \
    -f pool_layer.f \
    -o pool_layer_sim

./obj_dir/pool_layer_sim | tee "$LOG"

if grep -qF ">>> FAIL" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"

//--- sim/pool_layer_tb.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module pool_layer_tb;

    import pool_pkg::*;

    localparam int SEED             = 11401;
    localparam int CLK_HALF         = 50;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_FRAMES       = 18;
    localparam int CYCLES_PER_FRAME = 400;
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + NUM_FRAMES * CYCLES_PER_FRAME;
    localparam int IFM_SIZE         = `POOL_IFM_SIZE;
    localparam int OFM_SIZE         = `POOL_OFM_SIZE;
    localparam int STRIDE           = `POOL_STRIDE;
    localparam int IFM_PIXELS       = IFM_SIZE * IFM_SIZE;
    localparam int OFM_PIXELS       = OFM_SIZE * OFM_SIZE;
    localparam int PATTERN_LEN      = 8192;
    localparam int READ_SETTLE      = 8;
    localparam int HOLD_WAIT        = 20;

    logic      clk;
    logic      reset;
    logic      ifm_wr_en;
    ifm_addr_t ifm_wr_addr;
    pixel_t    ifm_wr_data;
    logic      start_from_previous;
    logic      end_to_previous;
    logic      conv_ready;
    ofm_addr_t ofm_rd_addr;
    pixel_t    ofm_rd_data;
    logic      end_from_next;
    logic      start_to_next;
    chan_sel_t ifm_sel_next;

    pixel_t    ifm_model [IFM_PIXELS];
    pixel_t    expected_map [OFM_PIXELS];
    pixel_t    held_map [OFM_PIXELS];
    bit        conv_pattern [PATTERN_LEN];
    chan_sel_t expected_sel;
    int        check_count = 0;
    int        error_count = 0;
    int        cycle_count = 0;
    int        frame;
    bit        map_held;

    pool_layer_top i_dut
    (
        .clk                 (clk),
        .reset               (reset),
        .ifm_wr_en           (ifm_wr_en),
        .ifm_wr_addr         (ifm_wr_addr),
        .ifm_wr_data         (ifm_wr_data),
        .start_from_previous (start_from_previous),
        .end_to_previous     (end_to_previous),
        .conv_ready          (conv_ready),
        .ofm_rd_addr         (ofm_rd_addr),
        .ofm_rd_data         (ofm_rd_data),
        .end_from_next       (end_from_next),
        .start_to_next       (start_to_next),
        .ifm_sel_next        (ifm_sel_next)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #CLK_HALF clk = ~clk;
    end

    // conv side readiness, about three cycles in four
    initial
    begin
        int idx;
        idx = 0;
        conv_ready <= 1'b1;
        forever
        begin
            @(posedge clk);
            conv_ready <= conv_pattern[idx];
            idx = (idx + 1) % PATTERN_LEN;
        end
    end

    always @(posedge clk)
    begin
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display(">>> FAIL");
            $finish;
        end
        else
        begin
            cycle_count = cycle_count + 1;
        end
    end

    task automatic check_pixel(input pixel_t actual, input pixel_t expected, input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_sel(input chan_sel_t actual, input chan_sel_t expected,
                             input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0t: %s, got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    function automatic pixel_t window_max(input pixel_t a, input pixel_t b,
                                          input pixel_t c, input pixel_t d);
        pixel_t m;
        m = a;
        if (b > m)
            m = b;
        if (c > m)
            m = c;
        if (d > m)
            m = d;
        return m;
    endfunction

    task automatic write_input_map();
        pixel_t pix;
        for (int i = 0; i < IFM_PIXELS; i++)
        begin
            pix = pixel_t'($urandom);
            ifm_model[i] = pix;
            @(posedge clk);
            ifm_wr_en   <= 1'b1;
            ifm_wr_addr <= ifm_addr_t'(i);
            ifm_wr_data <= pix;
        end
        @(posedge clk);
        ifm_wr_en <= 1'b0;
    endtask

    // 2x2 maxima in raster order of the output map
    task automatic build_expected_map();
        int top;
        for (int r = 0; r < OFM_SIZE; r++)
        begin
            for (int c = 0; c < OFM_SIZE; c++)
            begin
                top = r * STRIDE * IFM_SIZE + c * STRIDE;
                expected_map[r * OFM_SIZE + c] =
                    window_max(ifm_model[top], ifm_model[top + 1],
                               ifm_model[top + IFM_SIZE], ifm_model[top + IFM_SIZE + 1]);
            end
        end
    endtask

    task automatic start_frame();
        @(posedge clk);
        start_from_previous <= 1'b1;
        @(posedge clk);
        start_from_previous <= 1'b0;
        @(negedge clk);
        check_flag(end_to_previous, 1'b0, "end_to_previous after start_from_previous");
    endtask

    task automatic wait_reads_done();
        do
        begin
            @(negedge clk);
            check_flag(start_to_next, 1'b0, "start_to_next while end_from_next is low");
        end
        while (end_to_previous !== 1'b1);
    endtask

    task automatic check_output_map(input bit from_held, input string what);
        pixel_t expected;
        for (int i = 0; i < OFM_PIXELS; i++)
        begin
            expected = from_held ? held_map[i] : expected_map[i];
            @(posedge clk);
            ofm_rd_addr <= ofm_addr_t'(i);
            @(posedge clk);
            @(negedge clk);
            check_pixel(ofm_rd_data, expected,
                        $sformatf("frame %0d %s pixel %0d", frame, what, i));
        end
    endtask

    // next layer frees up after a random delay and takes the map
    task automatic release_map();
        int delay;
        delay = 1 + int'($urandom % 16);
        repeat (delay) @(posedge clk);
        end_from_next <= 1'b1;
        do
            @(negedge clk);
        while (start_to_next !== 1'b1);
        check_sel(ifm_sel_next, expected_sel, "ifm_sel_next at handoff");
        expected_sel = chan_sel_t'((int'(expected_sel) + 1) % `POOL_CHANNELS);
        // end_from_next still high, the pulse must end because the buffer is free
        @(negedge clk);
        check_flag(start_to_next, 1'b0, "start_to_next one cycle after handoff");
        check_sel(ifm_sel_next, expected_sel, "ifm_sel_next after handoff");
        @(posedge clk);
        end_from_next <= 1'b0;
        @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(SEED));
        for (int i = 0; i < PATTERN_LEN; i++)
            conv_pattern[i] = ($urandom % 4) != 0;

        reset               <= 1'b1;
        ifm_wr_en           <= 1'b0;
        ifm_wr_addr         <= '0;
        ifm_wr_data         <= '0;
        start_from_previous <= 1'b0;
        ofm_rd_addr         <= '0;
        end_from_next       <= 1'b0;
        expected_sel = '0;
        map_held = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(end_to_previous, 1'b1, "end_to_previous after reset");
        check_flag(start_to_next, 1'b0, "start_to_next after reset");
        check_sel(ifm_sel_next, expected_sel, "ifm_sel_next after reset");

        for (frame = 0; frame < NUM_FRAMES; frame++)
        begin
            check_flag(end_to_previous, 1'b1, "end_to_previous before input writes");
            if (map_held)
                held_map = expected_map;
            write_input_map();
            build_expected_map();
            start_frame();

            // previous map still waits, reads must stop after the first row
            if (map_held)
            begin
                repeat (HOLD_WAIT) @(posedge clk);
                @(negedge clk);
                check_flag(end_to_previous, 1'b0, "reads stalled behind held map");
                check_output_map(1'b1, "held");
                check_flag(end_to_previous, 1'b0, "reads still stalled after read-back");
                release_map();
                map_held = 1'b0;
            end

            wait_reads_done();
            repeat (READ_SETTLE) @(posedge clk);
            check_output_map(1'b0, "new");

            if ((frame % 3 == 1) && (frame != NUM_FRAMES - 1))
                map_held = 1'b1;
            else
                release_map();
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sim/pool_layer_sva.sv
`timescale 1ns/1ps

module pool_layer_sva
(
    input logic clk,
    input logic reset,
    input logic start_from_previous,
    input logic start_to_next,
    input logic end_to_previous,
    input logic rd_en
);

    // handoff releases the output buffer on the same edge
    property start_to_next_single_cycle;
        @(posedge clk) disable iff (reset)
            start_to_next |=> !start_to_next;
    endproperty

    // sequencer comes out of reset idle and ready for a new map
    property idle_after_reset;
        @(posedge clk)
            $fell(reset) |-> (end_to_previous && !rd_en && !start_to_next);
    endproperty

    // an idle sequencer only starts reading on start_from_previous
    property no_read_while_idle;
        @(posedge clk) disable iff (reset)
            (end_to_previous && !start_from_previous) |=> !rd_en;
    endproperty

    a_start_to_next_single_cycle: assert property (start_to_next_single_cycle)
        else $error("start_to_next stayed high for more than one cycle");

    a_idle_after_reset: assert property (idle_after_reset)
        else $error("control unit not idle when reset was released");

    a_no_read_while_idle: assert property (no_read_while_idle)
        else $error("rd_en went high without start_from_previous");

endmodule

bind pool_ctrl pool_layer_sva i_sva
(
    .clk                 (clk),
    .reset               (reset),
    .start_from_previous (start_from_previous),
    .start_to_next       (start_to_next),
    .end_to_previous     (end_to_previous),
    .rd_en               (rd_en)
);

//--- design/pool_layer_top.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module pool_layer_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ifm_wr_en,
    input  pool_pkg::ifm_addr_t ifm_wr_addr,
    input  pool_pkg::pixel_t    ifm_wr_data,
    input  logic                start_from_previous,
    output logic                end_to_previous,
    input  logic                conv_ready,
    input  pool_pkg::ofm_addr_t ofm_rd_addr,
    output pool_pkg::pixel_t    ofm_rd_data,
    input  logic                end_from_next,
    output logic                start_to_next,
    output pool_pkg::chan_sel_t ifm_sel_next
);

    import pool_pkg::*;

    logic      rd_en;
    ifm_addr_t rd_addr_a;
    pixel_t    rd_data_a;
    pixel_t    rd_data_b;
    logic      pair_valid;
    logic      pool_enable;
    pixel_t    upper_left;
    pixel_t    upper_right;
    pixel_t    pool_max;
    logic      ofm_wr_en;
    ofm_addr_t ofm_wr_addr;

    pool_ctrl i_ctrl
    (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .conv_ready          (conv_ready),
        .end_from_next       (end_from_next),
        .end_to_previous     (end_to_previous),
        .rd_en               (rd_en),
        .rd_addr_a           (rd_addr_a),
        .pair_valid          (pair_valid),
        .pool_enable         (pool_enable),
        .ofm_wr_en           (ofm_wr_en),
        .ofm_wr_addr         (ofm_wr_addr),
        .start_to_next       (start_to_next),
        .ifm_sel_next        (ifm_sel_next)
    );

    ifm_buffer i_ifm_buffer
    (
        .clk       (clk),
        .wr_en     (ifm_wr_en),
        .wr_addr   (ifm_wr_addr),
        .wr_data   (ifm_wr_data),
        .rd_en     (rd_en),
        .rd_addr_a (rd_addr_a),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    // current pair goes in, the pair one row up comes out
    line_fifo i_line_fifo
    (
        .clk       (clk),
        .reset     (reset),
        .shift     (pair_valid),
        .in_left   (rd_data_a),
        .in_right  (rd_data_b),
        .out_left  (upper_left),
        .out_right (upper_right)
    );

    max_pool_unit i_max_pool
    (
        .clk         (clk),
        .reset       (reset),
        .upper_left  (upper_left),
        .upper_right (upper_right),
        .lower_left  (rd_data_a),
        .lower_right (rd_data_b),
        .pool_max    (pool_max)
    );

    delay_line
    #(
        .WIDTH (1),
        .DEPTH (`POOL_PIPE_DEPTH)
    )
    i_wr_en_delay
    (
        .clk      (clk),
        .reset    (reset),
        .data_in  (pool_enable),
        .data_out (ofm_wr_en)
    );

    ofm_buffer i_ofm_buffer
    (
        .clk     (clk),
        .wr_en   (ofm_wr_en),
        .wr_addr (ofm_wr_addr),
        .wr_data (pool_max),
        .rd_addr (ofm_rd_addr),
        .rd_data (ofm_rd_data)
    );

endmodule

//--- design/pool_ctrl.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module pool_ctrl
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_from_previous,
    input  logic                  conv_ready,
    input  logic                  end_from_next,
    output logic                  end_to_previous,
    output logic                  rd_en,
    output pool_pkg::ifm_addr_t   rd_addr_a,
    output logic                  pair_valid,
    output logic                  pool_enable,
    input  logic                  ofm_wr_en,
    output pool_pkg::ofm_addr_t   ofm_wr_addr,
    output logic                  start_to_next,
    output pool_pkg::chan_sel_t   ifm_sel_next
);

    import pool_pkg::*;

    localparam int PAIRS_PER_ROW = `POOL_IFM_SIZE / `POOL_KERNEL_SIZE;
    localparam int COL_W = $clog2(PAIRS_PER_ROW);
    localparam int ROW_W = $clog2(`POOL_IFM_SIZE);

    // address of the last pair in the map
    localparam ifm_addr_t LAST_PAIR_ADDR =
        ifm_addr_t'(`POOL_IFM_SIZE * `POOL_IFM_SIZE - `POOL_KERNEL_SIZE);
    // last pair of row 0, the line FIFO is full after it
    localparam ifm_addr_t FILL_ADDR = ifm_addr_t'(`POOL_IFM_SIZE - `POOL_KERNEL_SIZE);
    localparam ofm_addr_t LAST_OFM_ADDR =
        ofm_addr_t'(`POOL_OFM_SIZE * `POOL_OFM_SIZE - 1);
    localparam chan_sel_t LAST_CHANNEL = chan_sel_t'(`POOL_CHANNELS - 1);

    read_state_t    read_state;
    read_state_t    read_next;
    window_state_t  win_state;
    handoff_state_t handoff_state;

    logic             last_pair;
    logic             fill_point;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             row_end;
    logic             last_row;
    logic             last_write;

    assign last_pair  = (rd_addr_a == LAST_PAIR_ADDR);
    assign fill_point = (rd_addr_a == FILL_ADDR);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            read_state <= IDLE;
        else
            read_state <= read_next;
    end

    always_comb
    begin
        read_next = read_state;
        case (read_state)
            IDLE, FINISH:
            begin
                if (start_from_previous)
                    read_next = READ;
            end
            READ:
            begin
                if (last_pair)
                    read_next = FINISH;
                else if (!conv_ready || (fill_point && handoff_state == FULL))
                    read_next = HOLD;
            end
            HOLD:
            begin
                // previous map must be handed off before row 1 is read
                if (conv_ready && handoff_state == EMPTY)
                    read_next = READ;
            end
            default:
                read_next = IDLE;
        endcase
    end

    assign rd_en           = (read_state == READ);
    assign end_to_previous = (read_state == IDLE) || (read_state == FINISH);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rd_addr_a <= '0;
        else if (rd_en)
            rd_addr_a <= last_pair ? '0 : ifm_addr_t'(rd_addr_a + `POOL_KERNEL_SIZE);
    end

    // read data shows up one cycle after rd_en
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pair_valid <= 1'b0;
        else
            pair_valid <= rd_en;
    end

    // window tracker, counts pairs as they shift into the line FIFO
    assign row_end  = (col_cnt == COL_W'(PAIRS_PER_ROW - 1));
    assign last_row = (row_cnt == ROW_W'(`POOL_IFM_SIZE - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_state <= FILL;
        end
        else if (pair_valid)
        begin
            if (row_end)
            begin
                col_cnt <= '0;
                row_cnt <= last_row ? '0 : ROW_W'(row_cnt + 1'b1);
                case (win_state)
                    FILL:    win_state <= POOL;
                    POOL:    win_state <= last_row ? FILL : SKIP;
                    SKIP:    win_state <= POOL;
                    default: win_state <= FILL;
                endcase
            end
            else
            begin
                col_cnt <= COL_W'(col_cnt + 1'b1);
            end
        end
    end

    // odd rows meet their upper row at the FIFO output
    assign pool_enable = pair_valid && (win_state == POOL);

    assign last_write = ofm_wr_en && (ofm_wr_addr == LAST_OFM_ADDR);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_wr_addr <= '0;
        else if (ofm_wr_en)
            ofm_wr_addr <= last_write ? '0 : ofm_addr_t'(ofm_wr_addr + 1'b1);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            handoff_state <= EMPTY;
        else
        begin
            case (handoff_state)
                EMPTY:
                begin
                    if (last_write)
                        handoff_state <= FULL;
                end
                FULL:
                begin
                    if (end_from_next)
                        handoff_state <= EMPTY;
                end
                default:
                    handoff_state <= EMPTY;
            endcase
        end
    end

    assign start_to_next = (handoff_state == FULL) && end_from_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ifm_sel_next <= '0;
        else if (start_to_next)
            ifm_sel_next <= (ifm_sel_next == LAST_CHANNEL) ? '0
                                                           : chan_sel_t'(ifm_sel_next + 1'b1);
    end

endmodule

//--- design/ofm_buffer.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module ofm_buffer
(
    input  logic                clk,
    input  logic                wr_en,
    input  pool_pkg::ofm_addr_t wr_addr,
    input  pool_pkg::pixel_t    wr_data,
    input  pool_pkg::ofm_addr_t rd_addr,
    output pool_pkg::pixel_t    rd_data
);

    import pool_pkg::*;

    localparam int DEPTH = `POOL_OFM_SIZE * `POOL_OFM_SIZE;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // next layer sees data one cycle after the address
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- design/max_pool_unit.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module max_pool_unit
(
    input  logic             clk,
    input  logic             reset,
    input  pool_pkg::pixel_t upper_left,
    input  pool_pkg::pixel_t upper_right,
    input  pool_pkg::pixel_t lower_left,
    input  pool_pkg::pixel_t lower_right,
    output pool_pkg::pixel_t pool_max
);

    import pool_pkg::*;

    pixel_t ul_q;
    pixel_t ur_q;
    pixel_t ll_q;
    pixel_t lr_q;
    pixel_t upper_max_q;
    pixel_t lower_max_q;

    // the write enable delay is sized from the same depth
    if (`POOL_PIPE_DEPTH != 3)
    begin : g_depth_check
        $error("max_pool_unit has three stages, POOL_PIPE_DEPTH must be 3");
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ul_q        <= '0;
            ur_q        <= '0;
            ll_q        <= '0;
            lr_q        <= '0;
            upper_max_q <= '0;
            lower_max_q <= '0;
            pool_max    <= '0;
        end
        else
        begin
            ul_q        <= upper_left;
            ur_q        <= upper_right;
            ll_q        <= lower_left;
            lr_q        <= lower_right;
            upper_max_q <= (ul_q > ur_q) ? ul_q : ur_q;
            lower_max_q <= (ll_q > lr_q) ? ll_q : lr_q;
            pool_max    <= (upper_max_q > lower_max_q) ? upper_max_q : lower_max_q;
        end
    end

endmodule

//--- design/line_fifo.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module line_fifo
(
    input  logic             clk,
    input  logic             reset,
    input  logic             shift,
    input  pool_pkg::pixel_t in_left,
    input  pool_pkg::pixel_t in_right,
    output pool_pkg::pixel_t out_left,
    output pool_pkg::pixel_t out_right
);

    import pool_pkg::*;

    // one map row holds this many pairs
    localparam int PAIRS = `POOL_IFM_SIZE / `POOL_KERNEL_SIZE;

    pixel_t left_q  [PAIRS];
    pixel_t right_q [PAIRS];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < PAIRS; i++)
            begin
                left_q[i]  <= '0;
                right_q[i] <= '0;
            end
        end
        else if (shift)
        begin
            left_q[0]  <= in_left;
            right_q[0] <= in_right;
            for (int i = 1; i < PAIRS; i++)
            begin
                left_q[i]  <= left_q[i-1];
                right_q[i] <= right_q[i-1];
            end
        end
    end

    // oldest pair, same column one row up
    assign out_left  = left_q[PAIRS-1];
    assign out_right = right_q[PAIRS-1];

endmodule

//--- design/ifm_buffer.sv
`timescale 1ns/1ps

`include "pool_config.svh"

module ifm_buffer
(
    input  logic                clk,
    input  logic                wr_en,
    input  pool_pkg::ifm_addr_t wr_addr,
    input  pool_pkg::pixel_t    wr_data,
    input  logic                rd_en,
    input  pool_pkg::ifm_addr_t rd_addr_a,
    output pool_pkg::pixel_t    rd_data_a,
    output pool_pkg::pixel_t    rd_data_b
);

    import pool_pkg::*;

    localparam int DEPTH = `POOL_IFM_SIZE * `POOL_IFM_SIZE;

    pixel_t    mem [DEPTH];
    ifm_addr_t rd_addr_b;

    // port B reads the right-hand pixel of the pair
    assign rd_addr_b = ifm_addr_t'(rd_addr_a + 1'b1);

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

endmodule

//--- design/delay_line.sv
`timescale 1ns/1ps

module delay_line
#(
    parameter int WIDTH = 1,
    parameter int DEPTH = 3
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] stages [DEPTH];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                stages[i] <= '0;
        end
        else
        begin
            stages[0] <= data_in;
            for (int i = 1; i < DEPTH; i++)
                stages[i] <= stages[i-1];
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

//--- design/pool_pkg.sv
`include "pool_config.svh"

package pool_pkg;

    typedef logic [`POOL_PIXEL_WIDTH-1:0] pixel_t;

    typedef logic [$clog2(`POOL_IFM_SIZE * `POOL_IFM_SIZE)-1:0] ifm_addr_t;

    typedef logic [$clog2(`POOL_OFM_SIZE * `POOL_OFM_SIZE)-1:0] ofm_addr_t;

    typedef logic [$clog2(`POOL_CHANNELS)-1:0] chan_sel_t;

    // read sequencer
    typedef enum logic [1:0] {
        IDLE,
        READ,
        HOLD,
        FINISH
    } read_state_t;

    // which row of the map the incoming pairs belong to
    typedef enum logic [1:0] {
        FILL,
        POOL,
        SKIP
    } window_state_t;

    // output buffer ownership
    typedef enum logic {
        EMPTY,
        FULL
    } handoff_state_t;

endpackage

//--- include/pool_config.svh
`ifndef POOL_CONFIG_SVH
`define POOL_CONFIG_SVH

// input map side and pooling window
`define POOL_IFM_SIZE     10
`define POOL_KERNEL_SIZE  2
`define POOL_STRIDE       2

// output map side, (IFM - KERNEL) / STRIDE + 1
`define POOL_OFM_SIZE     5

`define POOL_PIXEL_WIDTH  8
`define POOL_CHANNELS     16

// latency of the max pool pipeline
`define POOL_PIPE_DEPTH   3

`endif
